//--- Bender.yml
package:
  name: l1_data_cache

sources:
  - logic/l1d_pkg.sv
  - logic/l1d_line_store.sv
  - logic/l1d_mshr_file.sv
  - logic/l1d_controller.sv
  - logic/l1_data_cache.sv
  - target: test
    files:
      - bench/l1d_checker.sv
      - bench/l1d_tb.sv

//--- bench/l1d_checker.sv
/*
  l1d protocol checker
  valid/ready hold rules on all four channels, quiet outputs after reset
  and fill priority over LSU requests
*/
module l1d_checker (
  input logic               clk_in,
  input logic               rst_N_in,
  input l1d_pkg::lsu_req_t  lsu_req,
  input logic               lsu_req_valid,
  input logic               lsu_req_ready,
  input l1d_pkg::lsu_resp_t lsu_resp,
  input logic               lsu_resp_valid,
  input logic               lsu_resp_ready,
  input l1d_pkg::llc_req_t  llc_req,
  input logic               llc_req_valid,
  input logic               llc_req_ready,
  input l1d_pkg::llc_fill_t llc_fill,
  input logic               llc_fill_valid,
  input logic               llc_fill_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // a raised valid stays up with the same payload until taken
  lsu_req_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    lsu_req_valid && !lsu_req_ready |=> lsu_req_valid && $stable(lsu_req))
    else begin $error("lsu request dropped or changed"); fail_count++; end

  lsu_resp_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    lsu_resp_valid && !lsu_resp_ready |=> lsu_resp_valid && $stable(lsu_resp))
    else begin $error("lsu response dropped or changed"); fail_count++; end

  llc_req_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    llc_req_valid && !llc_req_ready |=> llc_req_valid && $stable(llc_req))
    else begin $error("llc request dropped or changed"); fail_count++; end

  llc_fill_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    llc_fill_valid && !llc_fill_ready |=> llc_fill_valid && $stable(llc_fill))
    else begin $error("llc fill dropped or changed"); fail_count++; end

  reset_quiet: assert property (@(posedge clk_in)
    !rst_N_in |=> !lsu_req_ready && !lsu_resp_valid && !llc_req_valid && !llc_fill_ready)
    else begin $error("control output high after reset"); fail_count++; end

  // fills win over new LSU requests
  fill_first: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    llc_fill_valid |-> !lsu_req_ready)
    else begin $error("lsu request accepted while a fill waits"); fail_count++; end

endmodule

bind l1_data_cache l1d_checker u_chk (.*);

//--- bench/l1d_tb.sv
/*
  l1d testbench
  LFSR-driven LSU traffic over six blocks in three shared sets, an LLC model
  with random fill delay, and a reference memory for value checks
*/
module l1d_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_REQS = 400;
  localparam int LIMIT  = N_REQS * 60;
  // pairs of blocks collide in sets 1, 5 and 10
  localparam l1d_pkg::block_addr_t BLOCKS [6] = '{17'h00001, 17'h00011, 17'h00005,
                                                 17'h00035, 17'h0000a, 17'h0007a};

  logic clk_in = 1'b0;
  logic rst_N_in = 1'b0;
  l1d_pkg::lsu_req_t  lsu_req;
  logic               lsu_req_valid, lsu_req_ready;
  l1d_pkg::lsu_resp_t lsu_resp;
  logic               lsu_resp_valid, lsu_resp_ready;
  l1d_pkg::llc_req_t  llc_req;
  logic               llc_req_valid, llc_req_ready;
  l1d_pkg::llc_fill_t llc_fill;
  logic               llc_fill_valid, llc_fill_ready;

  logic [31:0] lfsr = 32'hde6c8e75;
  int cycle, sent, n_out, hit_cycle;
  bit hit_pending;
  l1d_pkg::req_id_t hit_id;
  l1d_pkg::word_t ref_mem [l1d_pkg::paddr_t];
  l1d_pkg::word_t llc_mem [l1d_pkg::paddr_t];
  l1d_pkg::word_t exp_val [64];
  l1d_pkg::paddr_t exp_addr [64];
  bit exp_write [64];
  bit outstanding [64];
  int order_q [6][$];
  bit open_blk [6];
  bit written [6];
  l1d_pkg::block_addr_t resident [16];
  bit res_valid [16];
  l1d_pkg::block_addr_t rd_q [$];
  int due_q [$];

  l1_data_cache #(.MSHR_COUNT(4), .MSHR_DEPTH(4)) u_dut (.*);

  always #2 clk_in = ~clk_in;

  function automatic logic [63:0] lfsr_bits(int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic l1d_pkg::word_t mem_word(l1d_pkg::paddr_t a, bit llc_side);
    if (llc_side && llc_mem.exists(a)) return llc_mem[a];
    if (!llc_side && ref_mem.exists(a)) return ref_mem[a];
    // untouched words hold a marker plus their own byte address
    return {32'hc0ffee00, 32'(a)};
  endfunction

  function automatic l1d_pkg::line_t line_of(l1d_pkg::block_addr_t b, bit llc_side);
    l1d_pkg::line_t l;
    for (int w = 0; w < 4; w++) begin
      l[w*64 +: 64] = mem_word({b, 5'(w * 8)}, llc_side);
    end
    return l;
  endfunction

  function automatic int block_slot(l1d_pkg::block_addr_t b);
    for (int i = 0; i < 6; i++) begin
      if (BLOCKS[i] == b) return i;
    end
    return 0;
  endfunction

  task automatic fail_now(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [255:0] exp, logic [255:0] act);
    assert (exp === act) else begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(string what, logic cond);
    assert (cond === 1'b1) else fail_now(what);
  endtask

  task automatic finish_run();
    if (u_dut.u_chk.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("protocol assertion in the checker failed");
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    lsu_req = '0;
    lsu_req_valid = 1'b0;
    lsu_resp_ready = 1'b0;
    llc_req_ready = 1'b0;
    llc_fill = '0;
    llc_fill_valid = 1'b0;
  end

  // sample handshakes at the edge, then drive 1 ns later
  always @(posedge clk_in) begin : step
    int b, s;
    l1d_pkg::paddr_t a;
    l1d_pkg::req_id_t id;
    logic lsu_fire, resp_fire, llc_fire, fill_fire;
    cycle++;
    if (cycle >= LIMIT) fail_now("run hung, cycle limit reached before all responses");
    if (u_dut.u_chk.fail_count != 0) fail_now("protocol assertion in the checker failed");
    lsu_fire  = lsu_req_valid && lsu_req_ready;
    resp_fire = lsu_resp_valid && lsu_resp_ready;
    llc_fire  = llc_req_valid && llc_req_ready;
    fill_fire = llc_fill_valid && llc_fill_ready;
    if (rst_N_in) begin
      if (hit_pending && cycle == hit_cycle + 1) begin
        check_value("hit_latency", 1'b0, lsu_resp_valid);
      end
      if (hit_pending && cycle == hit_cycle + 2) begin
        check_value("hit_latency", 1'b1, lsu_resp_valid);
        check_value("hit_id", hit_id, lsu_resp.id);
        hit_pending = 1'b0;
      end
      if (lsu_fire) begin
        id = lsu_req.id;
        a = lsu_req.addr;
        b = block_slot(a[21:5]);
        s = a[8:5];
        if (res_valid[s] && resident[s] == a[21:5] && !open_blk[b]) begin
          hit_pending = 1'b1;
          hit_cycle = cycle;
          hit_id = id;
        end
        exp_val[id] = lsu_req.write ? '0 : mem_word(a, 1'b0);
        exp_addr[id] = a;
        exp_write[id] = lsu_req.write;
        if (lsu_req.write) ref_mem[a] = lsu_req.wdata;
        order_q[b].push_back(id);
        outstanding[id] = 1'b1;
        n_out++;
      end
      if (resp_fire) begin
        id = lsu_resp.id;
        b = block_slot(lsu_resp.addr[21:5]);
        check_true("response for an id that is not in flight", outstanding[id]);
        check_true("response with no request waiting on its block", order_q[b].size() != 0);
        check_value("resp_order", order_q[b].pop_front(), id);
        check_value("resp_addr", exp_addr[id], lsu_resp.addr);
        check_value("resp_write", exp_write[id], lsu_resp.write);
        check_value("read_data", exp_val[id], lsu_resp.rdata);
        if (lsu_resp.write) written[b] = 1'b1;
        outstanding[id] = 1'b0;
        n_out--;
      end
      if (llc_fire) begin
        b = block_slot(llc_req.block);
        if (llc_req.wb) begin
          check_true("write-back of a block not written since its fill", written[b]);
          check_value("writeback_line", line_of(llc_req.block, 1'b0), llc_req.line);
          for (int w = 0; w < 4; w++) begin
            llc_mem[{llc_req.block, 5'(w * 8)}] = llc_req.line[w*64 +: 64];
          end
          written[b] = 1'b0;
        end else begin
          check_true("second LLC read for a block whose miss is open", !open_blk[b]);
          open_blk[b] = 1'b1;
          rd_q.push_back(llc_req.block);
          due_q.push_back(cycle + 2 + int'(lfsr_bits(3)));
        end
      end
      if (fill_fire) begin
        b = block_slot(llc_fill.block);
        open_blk[b] = 1'b0;
        written[b] = 1'b0;
        resident[llc_fill.block[3:0]] = llc_fill.block;
        res_valid[llc_fill.block[3:0]] = 1'b1;
      end
    end
    #1;
    rst_N_in = (cycle >= 8);
    if (rst_N_in) begin
      if (lsu_fire) sent++;
      if (!lsu_req_valid || lsu_fire) begin
        lsu_req_valid = (sent < N_REQS);
        s = int'(lfsr_bits(3)) % 6;
        lsu_req.addr  = {BLOCKS[s], l1d_pkg::OFFSET_BITS'(lfsr_bits(1) ? 16 : 8)};
        lsu_req.write = lfsr_bits(1);
        lsu_req.wdata = lfsr_bits(64);
        lsu_req.id    = l1d_pkg::req_id_t'(sent);
      end
      lsu_resp_ready = (lfsr_bits(2) != 0);
      llc_req_ready  = (lfsr_bits(2) != 0);
      if (fill_fire) llc_fill_valid = 1'b0;
      // reads come back in order once their delay has run out
      if (!llc_fill_valid && rd_q.size() != 0 && cycle >= due_q[0]) begin
        llc_fill.block = rd_q.pop_front();
        void'(due_q.pop_front());
        llc_fill.line = line_of(llc_fill.block, 1'b1);
        llc_fill_valid = 1'b1;
      end
      if (sent == N_REQS && n_out == 0 && !llc_fill_valid && rd_q.size() == 0) begin
        finish_run();
      end
    end
  end

endmodule

//--- logic/l1_data_cache.sv
/*
  l1 data cache
  non-blocking write-back L1D between the LSU and the LLC, built from the
  controller FSM, a direct-mapped line store and the MSHR file
*/
module l1_data_cache #(
  parameter int MSHR_COUNT = 4,
  parameter int MSHR_DEPTH = 4
) (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  l1d_pkg::lsu_req_t  lsu_req,
  input  logic               lsu_req_valid,
  output logic               lsu_req_ready,
  output l1d_pkg::lsu_resp_t lsu_resp,
  output logic               lsu_resp_valid,
  input  logic               lsu_resp_ready,
  output l1d_pkg::llc_req_t  llc_req,
  output logic               llc_req_valid,
  input  logic               llc_req_ready,
  input  l1d_pkg::llc_fill_t llc_fill,
  input  logic               llc_fill_valid,
  output logic               llc_fill_ready
);

  // line store commands and lookup results
  l1d_pkg::set_index_t  ls_index;
  l1d_pkg::addr_tag_t   ls_tag;
  logic [1:0]           ls_word_sel;
  logic                 ls_lookup, ls_write, ls_fill;
  l1d_pkg::word_t       ls_wdata;
  l1d_pkg::line_t       ls_fill_line;
  logic                 ls_hit, ls_victim_dirty;
  l1d_pkg::addr_tag_t   ls_victim_tag;
  l1d_pkg::word_t       ls_rdata;
  l1d_pkg::line_t       ls_rline;

  // MSHR file commands and status
  l1d_pkg::block_addr_t mf_addr;
  logic                 mf_alloc, mf_append, mf_pop;
  l1d_pkg::lsu_req_t    mf_entry;
  logic                 mf_match, mf_space, mf_head_valid;
  l1d_pkg::lsu_req_t    mf_head;

  l1d_controller u_ctrl (.*);

  l1d_line_store u_store (.*);

  l1d_mshr_file #(
    .MSHR_COUNT(MSHR_COUNT),
    .MSHR_DEPTH(MSHR_DEPTH)
  ) u_mshr (.*);

endmodule

//--- logic/l1d_controller.sv
/*
  l1d controller
  FSM that serves LSU hits, sends misses to the MSHR file and the LLC, and
  on a fill writes back a dirty victim, installs the line and replays the
  queued requests of that block in arrival order
*/
module l1d_controller (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  l1d_pkg::lsu_req_t    lsu_req,
  input  logic                 lsu_req_valid,
  output logic                 lsu_req_ready,
  output l1d_pkg::lsu_resp_t   lsu_resp,
  output logic                 lsu_resp_valid,
  input  logic                 lsu_resp_ready,
  output l1d_pkg::llc_req_t    llc_req,
  output logic                 llc_req_valid,
  input  logic                 llc_req_ready,
  input  l1d_pkg::llc_fill_t   llc_fill,
  input  logic                 llc_fill_valid,
  output logic                 llc_fill_ready,
  output l1d_pkg::set_index_t  ls_index,
  output l1d_pkg::addr_tag_t   ls_tag,
  output logic [1:0]           ls_word_sel,
  output logic                 ls_lookup,
  output logic                 ls_write,
  output logic                 ls_fill,
  output l1d_pkg::word_t       ls_wdata,
  output l1d_pkg::line_t       ls_fill_line,
  input  logic                 ls_hit,
  input  logic                 ls_victim_dirty,
  input  l1d_pkg::addr_tag_t   ls_victim_tag,
  input  l1d_pkg::word_t       ls_rdata,
  input  l1d_pkg::line_t       ls_rline,
  output l1d_pkg::block_addr_t mf_addr,
  output logic                 mf_alloc,
  output logic                 mf_append,
  output logic                 mf_pop,
  output l1d_pkg::lsu_req_t    mf_entry,
  input  logic                 mf_match,
  input  logic                 mf_space,
  input  logic                 mf_head_valid,
  input  l1d_pkg::lsu_req_t    mf_head
);

  l1d_pkg::ctrl_state_t state_q, state_d;
  l1d_pkg::lsu_req_t    req_q;
  l1d_pkg::llc_fill_t   fill_q;
  logic                 live_q;
  logic                 req_take, fill_take, fill_phase;
  logic                 in_replay;
  l1d_pkg::paddr_t      cmd_addr;
  l1d_pkg::block_addr_t cmd_block;
  l1d_pkg::block_addr_t victim_block;

  // handshakes open one cycle after reset releases; fills beat LSU requests
  assign llc_fill_ready = live_q && (state_q == l1d_pkg::IDLE);
  assign lsu_req_ready  = llc_fill_ready && !llc_fill_valid && mf_space;
  assign fill_take      = llc_fill_valid && llc_fill_ready;
  assign req_take       = lsu_req_valid && lsu_req_ready;

  assign in_replay  = (state_q == l1d_pkg::REPLAY);
  assign fill_phase = state_q inside {l1d_pkg::FILL_CHECK, l1d_pkg::EVICT, l1d_pkg::INSTALL,
                                      l1d_pkg::REPLAY, l1d_pkg::REPLAY_RESP};

  // address presented to the line store
  always_comb begin
    case (state_q)
      l1d_pkg::IDLE: begin
        cmd_addr = llc_fill_valid ? {llc_fill.block, l1d_pkg::OFFSET_BITS'(0)} : lsu_req.addr;
      end
      l1d_pkg::FILL_CHECK, l1d_pkg::EVICT, l1d_pkg::INSTALL: begin
        cmd_addr = {fill_q.block, l1d_pkg::OFFSET_BITS'(0)};
      end
      l1d_pkg::REPLAY: cmd_addr = mf_head.addr;
      default: cmd_addr = req_q.addr;
    endcase
  end

  assign cmd_block    = l1d_pkg::block_of(cmd_addr);
  assign ls_index     = cmd_block[l1d_pkg::INDEX_BITS-1:0];
  assign ls_tag       = cmd_block[l1d_pkg::BLOCK_BITS-1:l1d_pkg::INDEX_BITS];
  assign ls_word_sel  = l1d_pkg::word_of(cmd_addr);
  assign ls_wdata     = in_replay ? mf_head.wdata : req_q.wdata;
  assign ls_fill_line = fill_q.line;
  assign ls_fill      = (state_q == l1d_pkg::INSTALL);
  assign ls_lookup    = fill_take || req_take || (in_replay && mf_head_valid);
  // stores land on a hit, or when replayed after the install
  assign ls_write = ((state_q == l1d_pkg::LOOKUP) && ls_hit && req_q.write) ||
                    (in_replay && mf_head_valid && mf_head.write);

  assign mf_addr   = fill_phase ? fill_q.block : l1d_pkg::block_of(req_q.addr);
  assign mf_entry  = req_q;
  assign mf_alloc  = (state_q == l1d_pkg::ALLOC) && !mf_match;
  assign mf_append = (state_q == l1d_pkg::ALLOC) && mf_match;
  assign mf_pop    = in_replay && mf_head_valid;

  // one response path for hits and replays, writes answer zero
  assign lsu_resp_valid = state_q inside {l1d_pkg::RESPOND, l1d_pkg::REPLAY_RESP};
  assign lsu_resp = '{id:    req_q.id,
                      addr:  req_q.addr,
                      write: req_q.write,
                      rdata: req_q.write ? '0 : ls_rdata};

  assign victim_block  = {ls_victim_tag, fill_q.block[l1d_pkg::INDEX_BITS-1:0]};
  assign llc_req_valid = state_q inside {l1d_pkg::SEND_REQ, l1d_pkg::EVICT};
  assign llc_req = (state_q == l1d_pkg::EVICT) ?
                   l1d_pkg::llc_req_t'{block: victim_block, wb: 1'b1, line: ls_rline} :
                   l1d_pkg::llc_req_t'{block: l1d_pkg::block_of(req_q.addr), wb: 1'b0, line: '0};

  always_comb begin
    state_d = state_q;
    case (state_q)
      l1d_pkg::IDLE: begin
        if (fill_take) begin
          state_d = l1d_pkg::FILL_CHECK;
        end else if (req_take) begin
          state_d = l1d_pkg::LOOKUP;
        end
      end
      l1d_pkg::LOOKUP: state_d = ls_hit ? l1d_pkg::RESPOND : l1d_pkg::ALLOC;
      l1d_pkg::RESPOND: begin
        if (lsu_resp_ready) begin
          state_d = l1d_pkg::IDLE;
        end
      end
      // secondary misses just wait in their queue
      l1d_pkg::ALLOC: state_d = mf_match ? l1d_pkg::IDLE : l1d_pkg::SEND_REQ;
      l1d_pkg::SEND_REQ: begin
        if (llc_req_ready) begin
          state_d = l1d_pkg::IDLE;
        end
      end
      l1d_pkg::FILL_CHECK: begin
        if (ls_victim_dirty && (ls_victim_tag != ls_tag)) begin
          state_d = l1d_pkg::EVICT;
        end else begin
          state_d = l1d_pkg::INSTALL;
        end
      end
      l1d_pkg::EVICT: begin
        if (llc_req_ready) begin
          state_d = l1d_pkg::INSTALL;
        end
      end
      l1d_pkg::INSTALL: state_d = l1d_pkg::REPLAY;
      l1d_pkg::REPLAY: state_d = mf_head_valid ? l1d_pkg::REPLAY_RESP : l1d_pkg::IDLE;
      l1d_pkg::REPLAY_RESP: begin
        if (lsu_resp_ready) begin
          state_d = l1d_pkg::REPLAY;
        end
      end
      default: state_d = l1d_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= l1d_pkg::IDLE;
      live_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      live_q  <= 1'b1;
    end
  end

  // request under service: a new LSU request or the popped queue head
  always_ff @(posedge clk_in) begin
    if (req_take) begin
      req_q <= lsu_req;
    end else if (mf_pop) begin
      req_q <= mf_head;
    end
    if (fill_take) begin
      fill_q <= llc_fill;
    end
  end

endmodule

//--- logic/l1d_line_store.sv
/*
  l1d line store
  direct-mapped tag, valid, dirty and data arrays; a lookup registers hit,
  victim state, the addressed word and the whole line for the next cycle
*/
module l1d_line_store (
  input  logic                clk_in,
  input  logic                rst_N_in,
  input  l1d_pkg::set_index_t ls_index,
  input  l1d_pkg::addr_tag_t  ls_tag,
  input  logic [1:0]          ls_word_sel,
  input  logic                ls_lookup,
  input  logic                ls_write,
  input  l1d_pkg::word_t      ls_wdata,
  input  logic                ls_fill,
  input  l1d_pkg::line_t      ls_fill_line,
  output logic                ls_hit,
  output logic                ls_victim_dirty,
  output l1d_pkg::addr_tag_t  ls_victim_tag,
  output l1d_pkg::word_t      ls_rdata,
  output l1d_pkg::line_t      ls_rline
);

  l1d_pkg::line_t           data_q [l1d_pkg::SETS];
  l1d_pkg::addr_tag_t       tag_q  [l1d_pkg::SETS];
  logic [l1d_pkg::SETS-1:0] valid_q;
  logic [l1d_pkg::SETS-1:0] dirty_q;

  // a fill brings a clean line, a word write dirties it
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (ls_fill) begin
      valid_q[ls_index] <= 1'b1;
      dirty_q[ls_index] <= 1'b0;
    end else if (ls_write) begin
      dirty_q[ls_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (ls_fill) begin
      data_q[ls_index] <= ls_fill_line;
      tag_q[ls_index]  <= ls_tag;
    end else if (ls_write) begin
      data_q[ls_index][ls_word_sel*l1d_pkg::WORD_BITS +: l1d_pkg::WORD_BITS] <= ls_wdata;
    end
  end

  // lookup flags
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      ls_hit          <= 1'b0;
      ls_victim_dirty <= 1'b0;
    end else if (ls_lookup) begin
      ls_hit          <= valid_q[ls_index] && (tag_q[ls_index] == ls_tag);
      ls_victim_dirty <= valid_q[ls_index] && dirty_q[ls_index];
    end
  end

  // read data, held until the next lookup
  always_ff @(posedge clk_in) begin
    if (ls_lookup) begin
      ls_victim_tag <= tag_q[ls_index];
      ls_rline      <= data_q[ls_index];
      ls_rdata      <= data_q[ls_index][ls_word_sel*l1d_pkg::WORD_BITS +: l1d_pkg::WORD_BITS];
    end
  end

endmodule

//--- logic/l1d_mshr_file.sv
/*
  l1d MSHR file
  MSHR_COUNT block addresses, each owning a circular queue of up to
  MSHR_DEPTH waiting LSU requests; all commands act on the presented block
*/
module l1d_mshr_file #(
  parameter int MSHR_COUNT = 4,
  parameter int MSHR_DEPTH = 4
) (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  l1d_pkg::block_addr_t mf_addr,
  input  logic                 mf_alloc,
  input  logic                 mf_append,
  input  logic                 mf_pop,
  input  l1d_pkg::lsu_req_t    mf_entry,
  output logic                 mf_match,
  output logic                 mf_space,
  output logic                 mf_head_valid,
  output l1d_pkg::lsu_req_t    mf_head
);

  localparam int PTR_BITS = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(MSHR_DEPTH + 1);
  localparam int SEL_BITS = (MSHR_COUNT > 1) ? $clog2(MSHR_COUNT) : 1;

  logic [MSHR_COUNT-1:0] valid_q;
  l1d_pkg::block_addr_t  addr_q  [MSHR_COUNT];
  l1d_pkg::lsu_req_t     queue_q [MSHR_COUNT][MSHR_DEPTH];
  logic [PTR_BITS-1:0]   head_q  [MSHR_COUNT];
  logic [PTR_BITS-1:0]   tail_q  [MSHR_COUNT];
  logic [CNT_BITS-1:0]   count_q [MSHR_COUNT];

  logic [SEL_BITS-1:0] match_sel;
  logic [SEL_BITS-1:0] free_sel;
  logic                free_any;
  logic                any_full;

  function automatic logic [PTR_BITS-1:0] next_ptr(logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(MSHR_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // walk downward so the lowest free entry wins
  always_comb begin
    mf_match  = 1'b0;
    match_sel = '0;
    free_any  = 1'b0;
    free_sel  = '0;
    any_full  = 1'b0;
    for (int i = MSHR_COUNT - 1; i >= 0; i--) begin
      if (valid_q[i] && (addr_q[i] == mf_addr)) begin
        mf_match  = 1'b1;
        match_sel = SEL_BITS'(i);
      end
      if (!valid_q[i]) begin
        free_any = 1'b1;
        free_sel = SEL_BITS'(i);
      end
      if (count_q[i] == CNT_BITS'(MSHR_DEPTH)) begin
        any_full = 1'b1;
      end
    end
  end

  assign mf_space      = free_any && !any_full;
  assign mf_head_valid = mf_match && (count_q[match_sel] != '0);
  assign mf_head       = queue_q[match_sel][head_q[match_sel]];

  // queue pointers and entry lifetime
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      for (int i = 0; i < MSHR_COUNT; i++) begin
        head_q[i]  <= '0;
        tail_q[i]  <= '0;
        count_q[i] <= '0;
      end
    end else if (mf_alloc) begin
      valid_q[free_sel] <= 1'b1;
      head_q[free_sel]  <= '0;
      tail_q[free_sel]  <= next_ptr('0);
      count_q[free_sel] <= CNT_BITS'(1);
    end else if (mf_append) begin
      tail_q[match_sel]  <= next_ptr(tail_q[match_sel]);
      count_q[match_sel] <= count_q[match_sel] + 1'b1;
    end else if (mf_pop && mf_head_valid) begin
      head_q[match_sel]  <= next_ptr(head_q[match_sel]);
      count_q[match_sel] <= count_q[match_sel] - 1'b1;
      // last waiter gone, entry is free again
      if (count_q[match_sel] == CNT_BITS'(1)) begin
        valid_q[match_sel] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (mf_alloc) begin
      addr_q[free_sel]     <= mf_addr;
      queue_q[free_sel][0] <= mf_entry;
    end else if (mf_append) begin
      queue_q[match_sel][tail_q[match_sel]] <= mf_entry;
    end
  end

endmodule

//--- logic/l1d_pkg.sv
/*
  l1d shared definitions
  address geometry, word and line types, the four channel payloads and the
  controller state encoding for the direct-mapped write-back L1 data cache
*/
package l1d_pkg;

  localparam int PADDR_BITS  = 22;
  localparam int WORD_BITS   = 64;
  localparam int LINE_WORDS  = 4;
  localparam int SETS        = 16;
  localparam int OFFSET_BITS = 5;
  localparam int INDEX_BITS  = 4;
  localparam int TAG_BITS    = 13;
  localparam int REQ_ID_BITS = 6;
  localparam int BLOCK_BITS  = PADDR_BITS - OFFSET_BITS;

  typedef logic [PADDR_BITS-1:0]           paddr_t;
  typedef logic [BLOCK_BITS-1:0]           block_addr_t;
  typedef logic [INDEX_BITS-1:0]           set_index_t;
  typedef logic [TAG_BITS-1:0]             addr_tag_t;
  typedef logic [WORD_BITS-1:0]            word_t;
  typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;
  typedef logic [REQ_ID_BITS-1:0]          req_id_t;

  typedef struct packed {
    paddr_t  addr;
    logic    write;
    word_t   wdata;
    req_id_t id;
  } lsu_req_t;

  typedef struct packed {
    req_id_t id;
    paddr_t  addr;
    logic    write;
    word_t   rdata;
  } lsu_resp_t;

  // wb set means the line is a write-back, otherwise a line read
  typedef struct packed {
    block_addr_t block;
    logic        wb;
    line_t       line;
  } llc_req_t;

  typedef struct packed {
    block_addr_t block;
    line_t       line;
  } llc_fill_t;

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP,
    RESPOND,
    ALLOC,
    SEND_REQ,
    FILL_CHECK,
    EVICT,
    INSTALL,
    REPLAY,
    REPLAY_RESP
  } ctrl_state_t;

  function automatic block_addr_t block_of(paddr_t a);
    return a[PADDR_BITS-1:OFFSET_BITS];
  endfunction

  // word position inside the line, byte bits dropped
  function automatic logic [1:0] word_of(paddr_t a);
    return a[OFFSET_BITS-1:OFFSET_BITS-2];
  endfunction

endpackage

//--- sources.f
logic/l1d_pkg.sv
logic/l1d_line_store.sv
logic/l1d_mshr_file.sv
logic/l1d_controller.sv
logic/l1_data_cache.sv
bench/l1d_checker.sv
bench/l1d_tb.sv
